//--- Makefile
# Verilator simulation of the CPU memory subsystem

TOP = tb_cpu_mem_subsystem
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_cpu_mem_subsystem.sv
/* CPU memory subsystem testbench */

`timescale 1ns/1ps

module tb_cpu_mem_subsystem;

  localparam int  NUM_BANKS   = 4;
  localparam int  BANK_DEPTH  = 4096;
  localparam int  WORDS       = NUM_BANKS * BANK_DEPTH;
  localparam time CLK_PERIOD  = 100;
  localparam time MMIO_PERIOD = 70;
  localparam int  RESET_CYC   = 10;
  // Bus edges from request to the accepting edge
  localparam int  RD_CYC      = 4;
  localparam int  WR_CYC      = 5;
  // clk_mmio edges from address to data
  localparam int  MMIO_LAT    = 2;
  localparam int  RAND_OPS    = 200;
  localparam int  OP_BUDGET   = 6;
  localparam int  MAX_OPS     = 64;

  // Op codes of the data file
  localparam logic [31:0] OP_WR   = 32'd1;
  localparam logic [31:0] OP_RD   = 32'd2;
  localparam logic [31:0] OP_MMIO = 32'd3;

  logic        clk;
  logic        rst;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        clk_mmio;
  logic [31:0] mmio_raddr;
  logic [31:0] mmio_data;

  // Five words per op: op, word address, strobe, data, expected
  logic [31:0] testdata [MAX_OPS*5];
  // Sparse reference memory keyed by wrapped word address
  logic [31:0] model [int];
  int          errors;
  int          checks;
  int          n_ops;
  bit          loaded;
  integer      seed;

  cpu_mem_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_DEPTH(BANK_DEPTH)
  ) i_cpu_mem_subsystem (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .clk_mmio  (clk_mmio),
    .mmio_raddr(mmio_raddr),
    .mmio_data (mmio_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;
  always #(MMIO_PERIOD/2) clk_mmio = ~clk_mmio;

  // Unwritten words read as zero
  function automatic logic [31:0] model_read(input logic [31:0] word_addr);
    int key;
    key = int'(word_addr % WORDS);
    if (model.exists(key)) begin
      return model[key];
    end
    return '0;
  endfunction

  // Strobed lanes of the new word replace the old ones
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  lanes);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic model_write(input logic [31:0] word_addr, input logic [31:0] data,
                             input logic [3:0] lanes);
    model[int'(word_addr % WORDS)] = merge_lanes(model_read(word_addr), data, lanes);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("[ERROR] %0t: %s expected %h, actual %h", $time, name, expected, actual);
  endtask

  // Starts on a falling clk edge, ends on the falling edge after acceptance
  task automatic bus_access(input logic [31:0] word_addr, input logic [3:0] lanes,
                            input logic [31:0] data, output logic [31:0] rdata);
    int cycles;
    int expected_cycles;
    expected_cycles = (lanes != 4'h0) ? WR_CYC : RD_CYC;
    mem_valid = 1'b1;
    mem_addr  = word_addr << 2;
    mem_wdata = data;
    mem_wstrb = lanes;
    // First rising edge already counts
    cycles = 1;
    do begin
      @(negedge clk);
      cycles++;
    end while (!mem_ready && cycles < 4 * WR_CYC);
    rdata = mem_rdata;
    checks++;
    if (!mem_ready) begin
      errors++;
      $display("mem_ready never came for the request at word address %h", word_addr);
    end else if (cycles != expected_cycles) begin
      errors++;
      $display("[ERROR] %0t: mem_ready latency expected %0d, actual %0d cycles",
               $time, expected_cycles, cycles);
    end
    // Request held through the accepting edge
    @(negedge clk);
    checks++;
    if (mem_ready !== 1'b0) begin
      report_mismatch("mem_ready", 32'd0, 32'(mem_ready));
    end
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
  endtask

  // Display port read, back on a falling clk edge at the end
  task automatic mmio_read(input logic [31:0] word_addr, output logic [31:0] rdata);
    @(negedge clk_mmio);
    mmio_raddr = word_addr;
    repeat (MMIO_LAT) @(negedge clk_mmio);
    rdata = mmio_data;
    @(negedge clk);
  endtask

  initial begin : main
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic [31:0] r;
    logic [3:0]  lanes;
    $timeformat(-9, 0, " ns", 0);
    seed       = 2;
    errors     = 0;
    checks     = 0;
    clk        = 1'b0;
    clk_mmio   = 1'b0;
    rst        = 1'b1;
    mem_valid  = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = '0;
    mmio_raddr = '0;

    $readmemh("bench/testdata_bus.txt", testdata);
    n_ops = 0;
    while (n_ops < MAX_OPS && testdata[n_ops*5] inside {OP_WR, OP_RD, OP_MMIO}) begin
      n_ops++;
    end
    loaded = 1'b1;
    if (n_ops == 0) begin
      errors++;
      $display("No operations could be read from bench/testdata_bus.txt");
    end

    repeat (RESET_CYC) @(negedge clk);
    rst = 1'b0;

    // Idle bus after reset
    repeat (3) begin
      @(negedge clk);
      checks++;
      if (mem_ready !== 1'b0) begin
        report_mismatch("mem_ready", 32'd0, 32'(mem_ready));
      end
    end

    // Directed ops from the data file
    for (int k = 0; k < n_ops; k++) begin
      op       = testdata[5*k];
      addr     = testdata[5*k+1];
      lanes    = testdata[5*k+2][3:0];
      data     = testdata[5*k+3];
      expected = testdata[5*k+4];
      if (op == OP_WR) begin
        bus_access(addr, lanes, data, rdata);
        model_write(addr, data, lanes);
      end else begin
        // File and bench model must agree
        if (model_read(addr) !== expected) begin
          errors++;
          $display("Data file entry %0d expects %h but the bench model holds %h",
                   k, expected, model_read(addr));
        end
        if (op == OP_RD) begin
          bus_access(addr, 4'h0, 32'h0, rdata);
          checks++;
          if (rdata !== expected) begin
            report_mismatch("mem_rdata", expected, rdata);
          end
        end else begin
          mmio_read(addr, rdata);
          checks++;
          if (rdata !== expected) begin
            report_mismatch("mmio_data", expected, rdata);
          end
        end
      end
    end

    // Random writes and reads over a few words of every bank
    for (int k = 0; k < RAND_OPS; k++) begin
      r = $random(seed);
      // Offset 0..7, bank from r[1:0], r[5] sets an alias above the top
      addr = {17'b0, r[5], r[1:0], 9'b0, r[4:2]};
      if (r[8]) begin
        lanes = (r[12:9] == 4'h0) ? 4'hf : r[12:9];
        data  = $random(seed);
        bus_access(addr, lanes, data, rdata);
        model_write(addr, data, lanes);
      end else begin
        bus_access(addr, 4'h0, 32'h0, rdata);
        checks++;
        if (rdata !== model_read(addr)) begin
          report_mismatch("mem_rdata", model_read(addr), rdata);
        end
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Six bus cycles per op covers the slowest access plus realignment
  initial begin : watchdog
    time limit;
    wait (loaded);
    limit = (n_ops + RAND_OPS) * OP_BUDGET * CLK_PERIOD + RESET_CYC * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired after %0t, the bus operations did not finish", limit);
    $display("Test failed");
    $finish;
  end

endmodule

//--- bench/testdata_bus.txt
// op addr strb data expected, all hex; op 1 bus write, 2 bus read, 3 MMIO read
// addr is a word address; reads ignore strb and data, writes ignore expected
// a line of zeros ends the list
2 00000000 0 00000000 00000000
1 00000000 f 11223344 00000000
2 00000000 0 00000000 11223344
1 00001000 f 55667788 00000000
1 00002000 f 99aabbcc 00000000
1 00003000 f ddeeff00 00000000
2 00000000 0 00000000 11223344
2 00001000 0 00000000 55667788
2 00002000 0 00000000 99aabbcc
2 00003000 0 00000000 ddeeff00
1 00000010 f a5a5a5a5 00000000
1 00000010 1 00000012 00000000
2 00000010 0 00000000 a5a5a512
1 00000010 4 00340000 00000000
2 00000010 0 00000000 a534a512
1 00000010 a 56007800 00000000
2 00000010 0 00000000 56347812
1 00001abc 6 ffeeddcc 00000000
2 00001abc 0 00000000 00eedd00
3 00000000 0 00000000 11223344
3 00001000 0 00000000 55667788
3 00000010 0 00000000 56347812
3 00001abc 0 00000000 00eedd00
3 00003fff 0 00000000 00000000
1 00004005 f cafef00d 00000000
2 00000005 0 00000000 cafef00d
2 00008005 0 00000000 cafef00d
3 00000005 0 00000000 cafef00d
1 0000ffff f 12345678 00000000
2 00003fff 0 00000000 12345678
3 00007fff 0 00000000 12345678
1 00002000 9 aa0000bb 00000000
2 00002000 0 00000000 aaaabbbb
2 00006000 0 00000000 aaaabbbb
3 00002000 0 00000000 aaaabbbb
1 00003000 2 0000be00 00000000
2 00003000 0 00000000 ddeebe00
0 00000000 0 00000000 00000000

//--- filelist.f
hw/cpu_bus_pkg.sv
hw/mem_geom_pkg.sv
hw/ram_bank.sv
hw/bank_read_mux.sv
hw/bus_bridge.sv
hw/cpu_mem_subsystem.sv
bench/tb_cpu_mem_subsystem.sv

//--- hw/bank_read_mux.sv
/* Bank read data selector */

`timescale 1ns/1ps

module bank_read_mux
  import cpu_bus_pkg::*;
  import mem_geom_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 4096
) (
  input  logic                                    clk,
  input  logic                                    clk_mmio,
  input  logic                                    rst,

  // Word addresses as presented to the banks
  input  logic [$clog2(NUM_BANKS*BANK_DEPTH)-1:0] addr_a,
  input  logic [$clog2(NUM_BANKS*BANK_DEPTH)-1:0] addr_b,

  // Per-bank outputs, already RAM_LATENCY behind their addresses
  input  bus_word_t [NUM_BANKS-1:0]               bank_rdata_a,
  input  bus_word_t [NUM_BANKS-1:0]               bank_rdata_b,

  output bus_word_t                               rdata_a,
  output bus_word_t                               rdata_b
);

  localparam int OFFS_W = $clog2(BANK_DEPTH);
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ADDR_W = OFFS_W + BANK_W;

  // Bank index pipelines, one per port clock
  logic [BANK_W-1:0] idx_a_q [RAM_LATENCY];
  logic [BANK_W-1:0] idx_b_q [RAM_LATENCY];

  // Bridge side
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RAM_LATENCY; i++) begin
        idx_a_q[i] <= '0;
      end
    end else begin
      idx_a_q[0] <= addr_a[ADDR_W-1:OFFS_W];
      for (int i = 1; i < RAM_LATENCY; i++) begin
        idx_a_q[i] <= idx_a_q[i-1];
      end
    end
  end

  // Display side, free running
  // keeps each address paired with its own data
  always_ff @(posedge clk_mmio) begin
    idx_b_q[0] <= addr_b[ADDR_W-1:OFFS_W];
    for (int i = 1; i < RAM_LATENCY; i++) begin
      idx_b_q[i] <= idx_b_q[i-1];
    end
  end

  assign rdata_a = bank_rdata_a[idx_a_q[RAM_LATENCY-1]];
  assign rdata_b = bank_rdata_b[idx_b_q[RAM_LATENCY-1]];

endmodule

//--- hw/bus_bridge.sv
/* CPU bus to banked RAM bridge */

`timescale 1ns/1ps

module bus_bridge
  import cpu_bus_pkg::*;
  import mem_geom_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 4096
) (
  input  logic                                    clk,
  input  logic                                    rst,

  // CPU side
  input  logic                                    mem_valid,
  input  logic [WORD_W-1:0]                       mem_addr,
  input  bus_word_t                               mem_wdata,
  input  logic [STRB_W-1:0]                       mem_wstrb,
  output logic                                    mem_ready,
  output bus_word_t                               mem_rdata,

  // Bank side with address and data shared by all banks
  output logic [$clog2(NUM_BANKS*BANK_DEPTH)-1:0] ram_addr,
  output bus_word_t                               ram_wdata,
  output logic [NUM_BANKS-1:0]                    ram_we,
  input  bus_word_t                               ram_rdata
);

  localparam int OFFS_W = $clog2(BANK_DEPTH);
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ADDR_W = OFFS_W + BANK_W;

  // Old word is at the bank output on this step
  localparam int MERGE_STEP = WR_LAST_CYCLE - 1;

  logic [STEP_W-1:0] step;
  logic [STEP_W-1:0] last_step;
  logic              is_write;
  logic [BANK_W-1:0] bank_sel;
  logic [NUM_BANKS-1:0] bank_onehot;
  bus_word_t         merged;

  // Any strobe bit makes it a read-modify-write
  assign is_write  = |mem_wstrb;
  assign last_step = is_write ? STEP_W'(WR_LAST_CYCLE) : STEP_W'(RD_LAST_CYCLE);

  // Ready on the last step only
  assign mem_ready = mem_valid && (step == last_step);

  // Read data straight from the selector
  assign mem_rdata = ram_rdata;

  // Bank chosen by the bits just above the in-bank offset
  assign bank_sel    = ram_addr[ADDR_W-1:OFFS_W];
  assign bank_onehot = NUM_BANKS'(1) << bank_sel;

  // Strobed lanes of the new word over the old one
  always_comb begin
    merged = ram_rdata;
    for (int i = 0; i < STRB_W; i++) begin
      if (mem_wstrb[i]) begin
        merged.bytes[i] = mem_wdata.bytes[i];
      end
    end
  end

  // Sequencer
  // Read steps 0 latch, 1 and 2 RAM pipeline, 3 data out with ready
  // Write steps 0 latch, 1 and 2 RAM pipeline, 3 merge and enable, 4 write lands with ready
  always_ff @(posedge clk) begin
    if (rst) begin
      step     <= '0;
      ram_we   <= '0;
      ram_addr <= '0;
    end else begin
      // Enable held for a single edge
      ram_we <= '0;
      if (mem_valid) begin
        step <= (step == last_step) ? '0 : step + 1'b1;

        // Word address with the upper bits dropped so accesses wrap
        if (step == '0) begin
          ram_addr <= mem_addr[ADDR_W+1:2];
        end

        if (is_write && step == STEP_W'(MERGE_STEP)) begin
          ram_we <= bank_onehot;
        end
      end
    end
  end

  // Merged word, captured with the enable
  always_ff @(posedge clk) begin
    if (mem_valid && is_write && step == STEP_W'(MERGE_STEP)) begin
      ram_wdata <= merged;
    end
  end

  // Master holds the request until ready
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb)
  ) else $error("bus request changed before mem_ready");

  // One bank writes, and only in the accepting step of a write
  a_we_onehot: assert property (
    @(posedge clk) disable iff (rst)
    (ram_we != '0) |-> $onehot(ram_we) && mem_ready && is_write
  ) else $error("bank write enable outside the accepting step of a single-bank write");

endmodule

//--- hw/cpu_bus_pkg.sv
/* CPU bus word definitions */

package cpu_bus_pkg;

  // Bus and memory word width
  localparam int WORD_W = 32;

  // Byte lanes per word, one strobe bit each
  localparam int STRB_W = 4;

  // Bits per byte lane
  localparam int LANE_W = WORD_W / STRB_W;

  // One bus word, two decodings
  // word: addresses and whole-word RAM data
  // bytes: per-lane merge under the write strobe
  typedef union packed {
    logic [WORD_W-1:0]             word;
    logic [STRB_W-1:0][LANE_W-1:0] bytes;
  } bus_word_t;

endpackage

//--- hw/cpu_mem_subsystem.sv
/* CPU memory subsystem top */

`timescale 1ns/1ps

module cpu_mem_subsystem
  import cpu_bus_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 4096
) (
  input  logic              clk,
  input  logic              rst,

  // CPU native memory bus
  input  logic              mem_valid,
  input  logic [WORD_W-1:0] mem_addr,
  input  logic [WORD_W-1:0] mem_wdata,
  input  logic [STRB_W-1:0] mem_wstrb,
  output logic              mem_ready,
  output logic [WORD_W-1:0] mem_rdata,

  // Frame-buffer read port
  input  logic              clk_mmio,
  input  logic [WORD_W-1:0] mmio_raddr,
  output logic [WORD_W-1:0] mmio_data
);

  localparam int OFFS_W = $clog2(BANK_DEPTH);
  localparam int ADDR_W = OFFS_W + $clog2(NUM_BANKS);

  logic [ADDR_W-1:0]           ram_addr;
  bus_word_t                   ram_wdata;
  logic [NUM_BANKS-1:0]        ram_we;
  bus_word_t                   ram_rdata;
  bus_word_t                   mmio_rdata;
  bus_word_t [NUM_BANKS-1:0]   bank_rdata_a;
  bus_word_t [NUM_BANKS-1:0]   bank_rdata_b;

  // MMIO word address, upper bits wrap
  logic [ADDR_W-1:0]           mmio_addr;

  assign mmio_addr = mmio_raddr[ADDR_W-1:0];
  assign mmio_data = mmio_rdata;

  bus_bridge #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_DEPTH(BANK_DEPTH)
  ) i_bus_bridge (
    .clk      (clk),
    .rst      (rst),
    .mem_valid(mem_valid),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .ram_addr (ram_addr),
    .ram_wdata(ram_wdata),
    .ram_we   (ram_we),
    .ram_rdata(ram_rdata)
  );

  // Banks share address and data, only the write enable differs
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    ram_bank #(
      .BANK_DEPTH(BANK_DEPTH)
    ) i_ram_bank (
      .clk     (clk),
      .clk_mmio(clk_mmio),
      .we      (ram_we[b]),
      .addr_a  (ram_addr[OFFS_W-1:0]),
      .wdata_a (ram_wdata),
      .rdata_a (bank_rdata_a[b]),
      .addr_b  (mmio_addr[OFFS_W-1:0]),
      .rdata_b (bank_rdata_b[b])
    );
  end

  bank_read_mux #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_DEPTH(BANK_DEPTH)
  ) i_bank_read_mux (
    .clk         (clk),
    .clk_mmio    (clk_mmio),
    .rst         (rst),
    .addr_a      (ram_addr),
    .addr_b      (mmio_addr),
    .bank_rdata_a(bank_rdata_a),
    .bank_rdata_b(bank_rdata_b),
    .rdata_a     (ram_rdata),
    .rdata_b     (mmio_rdata)
  );

endmodule

//--- hw/mem_geom_pkg.sv
/* Memory geometry and timing */

package mem_geom_pkg;

  // Address to registered bank output, in cycles of the port's clock
  localparam int RAM_LATENCY = 2;

  // Final sequence step of a read, ready shown here
  localparam int RD_LAST_CYCLE = 3;

  // Final sequence step of a read-modify-write
  localparam int WR_LAST_CYCLE = 4;

  // Step counter width, wide enough for the longer sequence
  localparam int STEP_W = $clog2(WR_LAST_CYCLE + 1);

endpackage

//--- hw/ram_bank.sv
/* Dual-clock word RAM bank */

`timescale 1ns/1ps

module ram_bank
  import cpu_bus_pkg::*;
#(
  parameter int BANK_DEPTH = 4096
) (
  input  logic                          clk,
  input  logic                          clk_mmio,

  // Port A, read and write on clk
  input  logic                          we,
  input  logic [$clog2(BANK_DEPTH)-1:0] addr_a,
  input  bus_word_t                     wdata_a,
  output bus_word_t                     rdata_a,

  // Port B, read only on clk_mmio
  input  logic [$clog2(BANK_DEPTH)-1:0] addr_b,
  output bus_word_t                     rdata_b
);

  bus_word_t mem [BANK_DEPTH];

  // First read stage of each port
  bus_word_t q_a;
  bus_word_t q_b;

  // Contents start at zero
  initial begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Port A
  // read-first, old word captured on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr_a] <= wdata_a;
    end
    q_a     <= mem[addr_a];
    rdata_a <= q_a;
  end

  // Port B
  // collides read-first with a port A write
  always_ff @(posedge clk_mmio) begin
    q_b     <= mem[addr_b];
    rdata_b <= q_b;
  end

  // Write address must be resolved
  a_we_addr_known: assert property (
    @(posedge clk)
    we |-> !$isunknown(addr_a)
  ) else $error("bank write with unknown address");

endmodule
